/* sim.f */
hw/routerPkg.sv
hw/routeCfgIf.sv
hw/regDecode.sv
hw/sourceSelect.sv
hw/sampleRoute.sv
hw/outputFormat.sv
hw/demodRouter.sv
sim/tbDemodRouter.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing
TOP      = tbDemodRouter
RTL_TOP  = demodRouter
FILELIST = sim.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@grep -q "Everything OK" $(LOG)

lint:
	$(TOOL) --lint-only -Wall $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* sim/tbDemodRouter.sv */
`default_nettype none

module tbDemodRouter;
  timeunit 1ns;
  timeprecision 1ps;

  import routerPkg::*;

  localparam int          NumRows    = 8;
  localparam int          AxiTimeout = 40;  // cycles per handshake wait
  localparam int          RstTimeout = 20;
  localparam logic [31:0] Seed       = 32'h3c6e739c;
  localparam logic [31:0] RouteMask  = 32'h0033_003F;  // dacInSel, decInSel, qOutSel fields

  logic                       clk;
  logic                       rs;
  logic [4:0]                 demodMode;
  logic [AddrWidth-1:0]       awAddr;
  logic                       awValid;
  logic                       awReady;
  logic [31:0]                wData;
  logic                       wValid;
  logic                       wReady;
  logic                       bValid;
  logic [1:0]                 bResp;
  logic                       bReady;
  logic [AddrWidth-1:0]       arAddr;
  logic                       arValid;
  logic                       arReady;
  logic                       rValid;
  logic [31:0]                rData;
  logic [1:0]                 rResp;
  logic                       rReady;
  logic                       dacRst;
  logic [2:0][DemodWidth-1:0] demodData;
  logic [2:0]                 demodSync;
  logic [2:0][18:0]           trellisSample;  // {data, sync}
  logic [2:0][18:0]           scSample;
  logic [2:0][3:0]            dacSelect;
  logic [3:0]                 demodBits;  // {i, q, symEn, sym2xEn}
  logic [3:0]                 trellisBits;
  logic [3:0]                 scBits;
  logic [2:0][DemodWidth-1:0] dacCode;
  logic [4:0]                 decOut;  // {i, q, symEn, sym2xEn, qBit}
  int                         errorCount;
  int                         testCount;
  int                         failedTests;

  // ******************************
  // stimulus table
  // ******************************
  logic [4:0]  modeTab [NumRows] = '{5'd0, ModePcmTrellis, ModeSoqpsk, ModeSoqpsk,
                                     ModeSoqpsk, ModeAqpsk, ModePcmTrellis, ModeAuqpsk};
  logic [11:0] dacSelTab [NumRows] = '{12'h000, 12'h3EC, 12'hFFD, 12'hCCC,
                                       12'hCCC, 12'h123, 12'hC5C, 12'hDEF};  // {ch2, ch1, ch0}
  logic [31:0] routeTab [NumRows] = '{32'h0, 32'h0, 32'h0, 32'h0010_0015, 32'h0010_0015,
                                      32'h0001_0000, 32'h0001_0000, 32'h0032_003E};
  logic [2:0]  syncTab [NumRows] = '{3'h7, 3'h7, 3'h7, 3'h7, 3'h0, 3'h7, 3'h7, 3'h5};
  logic [2:0][DemodWidth-1:0]  demodTab [NumRows];  // random columns
  logic [2:0][SampleWidth-1:0] trellisTab [NumRows];
  logic [2:0][SampleWidth-1:0] scTab [NumRows];
  logic [11:0]                 bitsTab [NumRows];  // {demod, trellis, sc}
  logic [2:0][DemodWidth-1:0]  expDac [NumRows];
  logic [4:0]                  expBits [NumRows];

  demodRouter i_demodRouter (
    .clk (clk), .rs (rs), .demodMode_i (demodMode),
    .sAxiAwaddr_i (awAddr), .sAxiAwvalid_i (awValid), .sAxiAwready_o (awReady),
    .sAxiWdata_i (wData), .sAxiWvalid_i (wValid), .sAxiWready_o (wReady),
    .sAxiBvalid_o (bValid), .sAxiBresp_o (bResp), .sAxiBready_i (bReady),
    .sAxiAraddr_i (arAddr), .sAxiArvalid_i (arValid), .sAxiArready_o (arReady),
    .sAxiRvalid_o (rValid), .sAxiRdata_o (rData), .sAxiRresp_o (rResp),
    .sAxiRready_i (rReady), .dacRst_o (dacRst),
    .demodData0_i (demodData[0]), .demodData1_i (demodData[1]), .demodData2_i (demodData[2]),
    .demodSync0_i (demodSync[0]), .demodSync1_i (demodSync[1]), .demodSync2_i (demodSync[2]),
    .trellisSample0_i (trellisSample[0]), .trellisSample1_i (trellisSample[1]),
    .trellisSample2_i (trellisSample[2]),
    .scSample0_i (scSample[0]), .scSample1_i (scSample[1]), .scSample2_i (scSample[2]),
    .dacSelect0_i (dacSelect[0]), .dacSelect1_i (dacSelect[1]), .dacSelect2_i (dacSelect[2]),
    .demodBits_i (demodBits), .trellisBits_i (trellisBits), .scBits_i (scBits),
    .dac0D_o (dacCode[0]), .dac1D_o (dacCode[1]), .dac2D_o (dacCode[2]),
    .decIBit_o (decOut[4]), .decQBit_o (decOut[3]), .decSymEn_o (decOut[2]),
    .decSym2xEn_o (decOut[1]), .qBit_o (decOut[0])
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ******************************
  // reference model
  // ******************************
  function automatic logic [18:0] pickSample(int row, int n);
    logic trellisOwned;
    trellisOwned = (modeTab[row] == ModePcmTrellis || modeTab[row] == ModeSoqpsk) &&
                   dacSelTab[row][4*n +: 4] >= DacTrellisI;
    if (routeTab[row][2*n +: 2] == SelSubcarrier) begin
      return {scTab[row][n], syncTab[row][n]};
    end else if (trellisOwned) begin
      return {trellisTab[row][n], syncTab[row][n]};
    end
    return {demodTab[row][n], {PadZeros{1'b0}}, syncTab[row][n]};  // other codes act as demod
  endfunction

  function automatic logic [DemodWidth-1:0] dacFromSample(logic [18:0] s,
                                                          logic [DemodWidth-1:0] held);
    if (s[0]) begin
      return {~s[18], s[17:5]};  // offset binary, top 14 data bits
    end
    return held;
  endfunction

  function automatic logic [4:0] expectBits(int row);
    logic [3:0] dem;
    logic [3:0] tre;
    logic [3:0] sc;
    logic [3:0] dec;
    logic       q;
    {dem, tre, sc} = bitsTab[row];
    if (routeTab[row][17:16] == DecSubcarrier) begin
      dec = sc;
    end else if (modeTab[row] == ModePcmTrellis || modeTab[row] == ModeSoqpsk) begin
      dec = {~tre[3], ~tre[3], tre[1:0]};  // corrected trellis decision on i and q
    end else begin
      dec = dem;
    end
    if (routeTab[row][21:20] == QOutSubcarrier) begin
      q = sc[2];
    end else if (modeTab[row] == ModeAqpsk || modeTab[row] == ModeAuqpsk) begin
      q = dem[2];
    end else begin
      q = dec[2];
    end
    return {dec, q};
  endfunction

  // ******************************
  // bus and check tasks
  // ******************************
  task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errorCount++;
    end
  endtask

  task automatic axiWrite(logic [AddrWidth-1:0] addr, logic [31:0] data);
    int waitCnt;
    waitCnt = 0;
    @(posedge clk);
    #2;
    awAddr  = addr;
    wData   = data;
    awValid = 1'b1;
    wValid  = 1'b1;
    bReady  = 1'b1;
    while (!(awReady && wReady) && waitCnt < AxiTimeout) begin
      @(posedge clk);
      #2;
      waitCnt++;
    end
    if (!(awReady && wReady)) begin
      $display("write to 0x%0h was never accepted", addr);
      errorCount++;
    end
    @(posedge clk);  // accept edge
    #2;
    awValid = 1'b0;
    wValid  = 1'b0;
    waitCnt = 0;
    while (!bValid && waitCnt < AxiTimeout) begin
      @(posedge clk);
      #2;
      waitCnt++;
    end
    if (!bValid) begin
      $display("no write response for address 0x%0h", addr);
      errorCount++;
    end else begin
      checkValue("sAxiBresp_o", 32'(bResp), 32'(RespOkay));
    end
    @(posedge clk);
    #2;
    bReady = 1'b0;
  endtask

  task automatic axiRead(logic [AddrWidth-1:0] addr, output logic [31:0] data);
    int waitCnt;
    waitCnt = 0;
    data    = '0;
    @(posedge clk);
    #2;
    arAddr  = addr;
    arValid = 1'b1;
    rReady  = 1'b1;
    while (!arReady && waitCnt < AxiTimeout) begin
      @(posedge clk);
      #2;
      waitCnt++;
    end
    if (!arReady) begin
      $display("read of 0x%0h was never accepted", addr);
      errorCount++;
    end
    @(posedge clk);
    #2;
    arValid = 1'b0;
    waitCnt = 0;
    while (!rValid && waitCnt < AxiTimeout) begin
      @(posedge clk);
      #2;
      waitCnt++;
    end
    if (!rValid) begin
      $display("no read data for address 0x%0h", addr);
      errorCount++;
    end else begin
      data = rData;
      checkValue("sAxiRresp_o", 32'(rResp), 32'(RespOkay));
    end
    @(posedge clk);
    #2;
    rReady = 1'b0;
  endtask

  task automatic driveRow(int row, logic active);
    @(posedge clk);
    #2;
    for (int n = 0; n < NumDacs; n++) begin
      demodData[n]     = demodTab[row][n];
      demodSync[n]     = active & syncTab[row][n];
      trellisSample[n] = {trellisTab[row][n], active & syncTab[row][n]};
      scSample[n]      = {scTab[row][n], active & syncTab[row][n]};
      dacSelect[n]     = dacSelTab[row][4*n +: 4];
    end
    {demodBits, trellisBits, scBits} = bitsTab[row];
  endtask

  task automatic reportTest(string name, int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore) begin
      $display("test %0d %s: pass", testCount, name);
    end else begin
      failedTests++;
      $display("test %0d %s: FAIL", testCount, name);
    end
  endtask

  initial begin
    logic [31:0]           rdValue;
    logic [DemodWidth-1:0] held [NumDacs];
    int                    errorsBefore;
    int                    waitCnt;
    {rs, demodMode, awAddr, awValid, wData, wValid, bReady} = {1'b1, 44'd0};
    {arAddr, arValid, rReady} = '0;
    {demodData, demodSync, trellisSample, scSample, dacSelect} = '0;
    {demodBits, trellisBits, scBits} = '0;
    {errorCount, testCount, failedTests} = '0;
    void'($urandom(Seed));
    for (int r = 0; r < NumRows; r++) begin
      for (int n = 0; n < NumDacs; n++) begin
        demodTab[r][n]   = DemodWidth'($urandom);
        trellisTab[r][n] = SampleWidth'($urandom);
        scTab[r][n]      = SampleWidth'($urandom);
      end
      bitsTab[r] = 12'($urandom);
    end
    // q mux inputs kept apart in the rows that select them
    bitsTab[3][2]  = bitsTab[3][7];   // sc q against corrected trellis q
    bitsTab[4][2]  = bitsTab[4][7];
    bitsTab[5][10] = ~bitsTab[5][2];  // raw q against subcarrier decoder q
    held = '{default: '0};  // codes clear on reset
    for (int r = 0; r < NumRows; r++) begin
      for (int n = 0; n < NumDacs; n++) begin
        expDac[r][n] = dacFromSample(pickSample(r, n), held[n]);
        held[n]      = expDac[r][n];
      end
      expBits[r] = expectBits(r);
    end

    repeat (8) @(posedge clk);
    #2;
    rs = 1'b0;

    errorsBefore = errorCount;
    waitCnt      = 0;
    while (dacRst && waitCnt < RstTimeout) begin
      @(posedge clk);
      #2;
      waitCnt++;
    end
    if (dacRst) begin
      $display("DAC reset still high long after reset release");
      errorCount++;
    end
    reportTest("reset release", errorsBefore);

    errorsBefore = errorCount;
    axiRead(RegVersion, rdValue);
    checkValue("RegVersion", rdValue, {VersionNumber, ImageType});
    axiWrite(RegRoute, 32'hFFFF_FFFF);
    axiRead(RegRoute, rdValue);
    checkValue("RegRoute", rdValue, 32'hFFFF_FFFF & RouteMask);
    axiWrite(4'hC, 32'h0);  // hole, must not touch the route
    axiRead(4'hC, rdValue);
    checkValue("unmapped read", rdValue, 32'h0);
    axiRead(RegReset, rdValue);
    checkValue("RegReset", rdValue, 32'h0);
    axiRead(RegRoute, rdValue);
    checkValue("RegRoute", rdValue, RouteMask);
    reportTest("registers", errorsBefore);

    // ******************************
    // routing rows
    // ******************************
    for (int r = 0; r < NumRows; r++) begin
      errorsBefore = errorCount;
      driveRow(r, 1'b0);  // syncs low while the route changes
      repeat (4) @(posedge clk);
      #2;
      demodMode = modeTab[r];
      axiWrite(RegRoute, routeTab[r]);
      driveRow(r, 1'b1);
      repeat (4) @(posedge clk);
      #2;
      checkValue("dac0D_o", 32'(dacCode[0]), 32'(expDac[r][0]));
      checkValue("dac1D_o", 32'(dacCode[1]), 32'(expDac[r][1]));
      checkValue("dac2D_o", 32'(dacCode[2]), 32'(expDac[r][2]));
      checkValue("decIBit_o", 32'(decOut[4]), 32'(expBits[r][4]));
      checkValue("decQBit_o", 32'(decOut[3]), 32'(expBits[r][3]));
      checkValue("decSymEn_o", 32'(decOut[2]), 32'(expBits[r][2]));
      checkValue("decSym2xEn_o", 32'(decOut[1]), 32'(expBits[r][1]));
      checkValue("qBit_o", 32'(decOut[0]), 32'(expBits[r][0]));
      reportTest($sformatf("route row %0d", r), errorsBefore);
    end

    errorsBefore = errorCount;
    axiWrite(RegReset, 32'h1);
    if (!dacRst) begin
      $display("DAC reset did not rise after the reset register write");
      errorCount++;
    end
    waitCnt = 0;
    while (dacRst && waitCnt < SoftResetCycles + 4) begin
      @(posedge clk);
      #2;
      waitCnt++;
    end
    if (dacRst) begin
      $display("DAC reset did not fall after the soft reset");
      errorCount++;
    end
    reportTest("soft reset", errorsBefore);

    $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/demodRouter.sv */
`default_nettype none

module demodRouter (
  input  logic                                  clk,
  input  logic                                  rs,
  input  logic [4:0]                            demodMode_i,
  // AXI4-Lite slave
  input  logic [routerPkg::AddrWidth-1:0]       sAxiAwaddr_i,
  input  logic                                  sAxiAwvalid_i,
  output logic                                  sAxiAwready_o,
  input  logic [31:0]                           sAxiWdata_i,
  input  logic                                  sAxiWvalid_i,
  output logic                                  sAxiWready_o,
  output logic                                  sAxiBvalid_o,
  output logic [1:0]                            sAxiBresp_o,
  input  logic                                  sAxiBready_i,
  input  logic [routerPkg::AddrWidth-1:0]       sAxiAraddr_i,
  input  logic                                  sAxiArvalid_i,
  output logic                                  sAxiArready_o,
  output logic                                  sAxiRvalid_o,
  output logic [31:0]                           sAxiRdata_o,
  output logic [1:0]                            sAxiRresp_o,
  input  logic                                  sAxiRready_i,
  output logic                                  dacRst_o,
  // sample and bit sources
  input  logic [routerPkg::DemodWidth-1:0]      demodData0_i,
  input  logic [routerPkg::DemodWidth-1:0]      demodData1_i,
  input  logic [routerPkg::DemodWidth-1:0]      demodData2_i,
  input  logic                                  demodSync0_i,
  input  logic                                  demodSync1_i,
  input  logic                                  demodSync2_i,
  input  logic [$bits(routerPkg::sampleT)-1:0]  trellisSample0_i,  // {data, sync}
  input  logic [$bits(routerPkg::sampleT)-1:0]  trellisSample1_i,
  input  logic [$bits(routerPkg::sampleT)-1:0]  trellisSample2_i,
  input  logic [$bits(routerPkg::sampleT)-1:0]  scSample0_i,
  input  logic [$bits(routerPkg::sampleT)-1:0]  scSample1_i,
  input  logic [$bits(routerPkg::sampleT)-1:0]  scSample2_i,
  input  logic [3:0]                            dacSelect0_i,
  input  logic [3:0]                            dacSelect1_i,
  input  logic [3:0]                            dacSelect2_i,
  input  logic [$bits(routerPkg::bitStreamT)-1:0] demodBits_i,  // {i, q, symEn, sym2xEn}
  input  logic [$bits(routerPkg::bitStreamT)-1:0] trellisBits_i,
  input  logic [$bits(routerPkg::bitStreamT)-1:0] scBits_i,
  // DAC and decoder side
  output logic [routerPkg::DemodWidth-1:0]      dac0D_o,
  output logic [routerPkg::DemodWidth-1:0]      dac1D_o,
  output logic [routerPkg::DemodWidth-1:0]      dac2D_o,
  output logic                                  decIBit_o,
  output logic                                  decQBit_o,
  output logic                                  decSymEn_o,
  output logic                                  decSym2xEn_o,
  output logic                                  qBit_o
);

  routeCfgIf cfgIf ();
  routeOutIf outIf ();

  regDecode i_regDecode (
    .clk, .rs, .demodMode_i,
    .sAxiAwaddr_i, .sAxiAwvalid_i, .sAxiAwready_o,
    .sAxiWdata_i, .sAxiWvalid_i, .sAxiWready_o,
    .sAxiBvalid_o, .sAxiBresp_o, .sAxiBready_i,
    .sAxiAraddr_i, .sAxiArvalid_i, .sAxiArready_o,
    .sAxiRvalid_o, .sAxiRdata_o, .sAxiRresp_o, .sAxiRready_i,
    .dacRst_o,
    .cfg (cfgIf.regs)
  );

  sampleRoute i_sampleRoute (
    .clk, .rs,
    .demodData0_i, .demodData1_i, .demodData2_i,
    .demodSync0_i, .demodSync1_i, .demodSync2_i,
    .trellisSample0_i, .trellisSample1_i, .trellisSample2_i,
    .scSample0_i, .scSample1_i, .scSample2_i,
    .dacSelect0_i, .dacSelect1_i, .dacSelect2_i,
    .demodBits_i, .trellisBits_i, .scBits_i,
    .cfg (cfgIf.router),
    .out (outIf.source)
  );

  outputFormat i_outputFormat (
    .clk, .rs,
    .cfg (cfgIf.formatter),
    .in  (outIf.sink),
    .dac0D_o, .dac1D_o, .dac2D_o,
    .decIBit_o, .decQBit_o, .decSymEn_o, .decSym2xEn_o,
    .qBit_o
  );

endmodule

`default_nettype wire

/* hw/outputFormat.sv */
`default_nettype none

module outputFormat (
  input  logic                             clk,
  input  logic                             rs,
  routeCfgIf.formatter                     cfg,
  routeOutIf.sink                          in,
  output logic [routerPkg::DemodWidth-1:0] dac0D_o,
  output logic [routerPkg::DemodWidth-1:0] dac1D_o,
  output logic [routerPkg::DemodWidth-1:0] dac2D_o,
  output logic                             decIBit_o,
  output logic                             decQBit_o,
  output logic                             decSymEn_o,
  output logic                             decSym2xEn_o,
  output logic                             qBit_o
);
  import routerPkg::*;

  logic [DemodWidth-1:0] dacCode [NumDacs];

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      for (int n = 0; n < NumDacs; n++) begin
        dacCode[n] <= '0;
      end
      {decIBit_o, decQBit_o, decSymEn_o, decSym2xEn_o} <= '0;
      qBit_o <= 1'b0;
    end else begin
      // offset binary for the converter, top bits only
      for (int n = 0; n < NumDacs; n++) begin
        if (in.dacSample[n].sync) begin
          dacCode[n] <= {~in.dacSample[n].data[SampleWidth-1],
                         in.dacSample[n].data[SampleWidth-2 -: DemodWidth-1]};
        end
      end
      {decIBit_o, decQBit_o, decSymEn_o, decSym2xEn_o} <= in.decBits;
      if (cfg.qOutSel == QOutSubcarrier) begin
        qBit_o <= in.scQBit;
      end else if (cfg.auQpskMode) begin
        qBit_o <= in.rawQBit;  // au modes bypass the decoder
      end else begin
        qBit_o <= in.decBits.qBit;
      end
    end
  end

  assign dac0D_o = dacCode[0];
  assign dac1D_o = dacCode[1];
  assign dac2D_o = dacCode[2];

endmodule

`default_nettype wire

/* hw/sampleRoute.sv */
`default_nettype none

module sampleRoute (
  input  logic                             clk,
  input  logic                             rs,
  input  logic [routerPkg::DemodWidth-1:0] demodData0_i,
  input  logic [routerPkg::DemodWidth-1:0] demodData1_i,
  input  logic [routerPkg::DemodWidth-1:0] demodData2_i,
  input  logic                             demodSync0_i,
  input  logic                             demodSync1_i,
  input  logic                             demodSync2_i,
  input  routerPkg::sampleT                trellisSample0_i,
  input  routerPkg::sampleT                trellisSample1_i,
  input  routerPkg::sampleT                trellisSample2_i,
  input  routerPkg::sampleT                scSample0_i,
  input  routerPkg::sampleT                scSample1_i,
  input  routerPkg::sampleT                scSample2_i,
  input  logic [3:0]                       dacSelect0_i,
  input  logic [3:0]                       dacSelect1_i,
  input  logic [3:0]                       dacSelect2_i,
  input  routerPkg::bitStreamT             demodBits_i,
  input  routerPkg::bitStreamT             trellisBits_i,
  input  routerPkg::bitStreamT             scBits_i,
  routeCfgIf.router                        cfg,
  routeOutIf.source                        out
);
  import routerPkg::*;

  logic [DemodWidth-1:0] demodData [NumDacs];
  logic                  demodSync [NumDacs];
  sampleT                trellisSample [NumDacs];
  sampleT                scSample [NumDacs];
  logic [3:0]            dacSelect [NumDacs];
  bitStreamT             demodBits;
  bitStreamT             trellisBits;
  bitStreamT             scBits;
  sampleT                demodCand [NumDacs];
  bitStreamT             decCand;

  // ******************************
  // pad reclocking
  // ******************************
  always_ff @(posedge clk) begin
    demodData[0]     <= demodData0_i;
    demodData[1]     <= demodData1_i;
    demodData[2]     <= demodData2_i;
    demodSync[0]     <= demodSync0_i;
    demodSync[1]     <= demodSync1_i;
    demodSync[2]     <= demodSync2_i;
    trellisSample[0] <= trellisSample0_i;
    trellisSample[1] <= trellisSample1_i;
    trellisSample[2] <= trellisSample2_i;
    scSample[0]      <= scSample0_i;
    scSample[1]      <= scSample1_i;
    scSample[2]      <= scSample2_i;
    dacSelect[0]     <= dacSelect0_i;
    dacSelect[1]     <= dacSelect1_i;
    dacSelect[2]     <= dacSelect2_i;
    demodBits        <= demodBits_i;
    trellisBits      <= trellisBits_i;
    scBits           <= scBits_i;
  end

  // trellis takes over a channel only for its own dacSelect codes
  always_comb begin
    for (int n = 0; n < NumDacs; n++) begin
      if (cfg.trellisMode && (dacSelect[n] inside
          {DacTrellisI, DacTrellisQ, DacTrellisPhErr, DacTrellisIndex})) begin
        demodCand[n] = trellisSample[n];
      end else begin
        demodCand[n].data = {demodData[n], {PadZeros{1'b0}}};
        demodCand[n].sync = demodSync[n];
      end
    end
  end

  always_comb begin
    if (cfg.trellisMode) begin
      decCand.iBit    = ~trellisBits.iBit;  // trellis decision polarity fix
      decCand.qBit    = ~trellisBits.iBit;
      decCand.symEn   = trellisBits.symEn;
      decCand.sym2xEn = trellisBits.sym2xEn;
    end else begin
      decCand = demodBits;
    end
  end

  for (genvar n = 0; n < NumDacs; n++) begin : genDacSel
    sourceSelect #(.payloadT(sampleT)) i_dacSel (
      .clk   (clk),
      .rs    (rs),
      .sel_i (cfg.dacInSel[n] == SelSubcarrier),
      .a_i   (demodCand[n]),
      .b_i   (scSample[n]),
      .y_o   (out.dacSample[n])
    );
  end

  sourceSelect #(.payloadT(bitStreamT)) i_decSel (
    .clk   (clk),
    .rs    (rs),
    .sel_i (cfg.decInSel == DecSubcarrier),
    .a_i   (decCand),
    .b_i   (scBits),
    .y_o   (out.decBits)
  );

  // q bits for the output mux, kept in step with decBits
  always_ff @(posedge clk) begin
    out.scQBit  <= scBits.qBit;
    out.rawQBit <= demodBits.qBit;
  end

endmodule

`default_nettype wire

/* hw/sourceSelect.sv */
`default_nettype none

// registered two-way source switch, any payload
module sourceSelect #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rs,
  input  logic    sel_i,  // 1 picks b_i
  input  payloadT a_i,
  input  payloadT b_i,
  output payloadT y_o
);

  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      y_o <= '0;  // strobes low out of reset
    end else if (sel_i) begin
      y_o <= b_i;
    end else begin
      y_o <= a_i;
    end
  end

endmodule

`default_nettype wire

/* hw/regDecode.sv */
`default_nettype none

module regDecode (
  input  logic                            clk,
  input  logic                            rs,
  input  logic [4:0]                      demodMode_i,
  input  logic [routerPkg::AddrWidth-1:0] sAxiAwaddr_i,
  input  logic                            sAxiAwvalid_i,
  output logic                            sAxiAwready_o,
  input  logic [31:0]                     sAxiWdata_i,
  input  logic                            sAxiWvalid_i,
  output logic                            sAxiWready_o,
  output logic                            sAxiBvalid_o,
  output logic [1:0]                      sAxiBresp_o,
  input  logic                            sAxiBready_i,
  input  logic [routerPkg::AddrWidth-1:0] sAxiAraddr_i,
  input  logic                            sAxiArvalid_i,
  output logic                            sAxiArready_o,
  output logic                            sAxiRvalid_o,
  output logic [31:0]                     sAxiRdata_o,
  output logic [1:0]                      sAxiRresp_o,
  input  logic                            sAxiRready_i,
  output logic                            dacRst_o,
  routeCfgIf.regs                         cfg
);
  import routerPkg::*;

  logic                   wrReady;
  logic                   wrAccept;
  logic                   rdAccept;
  logic [RstCntWidth-1:0] rstCnt;

  assign wrAccept      = wrReady & sAxiAwvalid_i & sAxiWvalid_i;
  assign rdAccept      = sAxiArready_o & sAxiArvalid_i;
  assign sAxiAwready_o = wrReady;  // aw and w accepted together
  assign sAxiWready_o  = wrReady;
  assign sAxiBresp_o   = RespOkay;
  assign sAxiRresp_o   = RespOkay;

  // ******************************
  // AXI handshakes
  // ******************************
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      wrReady       <= 1'b0;
      sAxiBvalid_o  <= 1'b0;
      sAxiArready_o <= 1'b0;
      sAxiRvalid_o  <= 1'b0;
    end else begin
      // one cycle ready pulses, held off while a response is pending
      wrReady       <= !wrReady && sAxiAwvalid_i && sAxiWvalid_i && !sAxiBvalid_o;
      sAxiArready_o <= !sAxiArready_o && sAxiArvalid_i && !sAxiRvalid_o;
      if (wrAccept) begin
        sAxiBvalid_o <= 1'b1;
      end else if (sAxiBready_i) begin
        sAxiBvalid_o <= 1'b0;
      end
      if (rdAccept) begin
        sAxiRvalid_o <= 1'b1;
      end else if (sAxiRready_i) begin
        sAxiRvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rdAccept) begin
      case (sAxiAraddr_i)
        RegVersion: sAxiRdata_o <= {VersionNumber, ImageType};
        RegRoute:   sAxiRdata_o <= {10'd0, cfg.qOutSel, 2'd0, cfg.decInSel, 10'd0,
                                    cfg.dacInSel[2], cfg.dacInSel[1], cfg.dacInSel[0]};
        default:    sAxiRdata_o <= '0;  // RegReset and holes
      endcase
    end
  end

  // route register and mode decode
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      for (int n = 0; n < NumDacs; n++) begin
        cfg.dacInSel[n] <= SelDemod;
      end
      cfg.decInSel    <= DecDemod;
      cfg.qOutSel     <= QOutDecoder;
      cfg.trellisMode <= 1'b0;
      cfg.auQpskMode  <= 1'b0;
    end else begin
      cfg.trellisMode <= demodMode_i inside {ModePcmTrellis, ModeSoqpsk};
      cfg.auQpskMode  <= demodMode_i inside {ModeAqpsk, ModeAuqpsk};
      if (wrAccept && sAxiAwaddr_i == RegRoute) begin
        for (int n = 0; n < NumDacs; n++) begin
          cfg.dacInSel[n] <= dacInSelT'(sAxiWdata_i[2*n +: 2]);
        end
        cfg.decInSel <= decInSelT'(sAxiWdata_i[17:16]);
        cfg.qOutSel  <= qOutSelT'(sAxiWdata_i[21:20]);
      end
    end
  end

  // ******************************
  // stretched DAC reset
  // ******************************
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      rstCnt   <= RstCntWidth'(SoftResetCycles);
      dacRst_o <= 1'b1;
    end else if (wrAccept && sAxiAwaddr_i == RegReset) begin
      rstCnt   <= RstCntWidth'(SoftResetCycles - 1);  // this cycle counts as one
      dacRst_o <= 1'b1;
    end else if (rstCnt != '0) begin
      rstCnt   <= rstCnt - 1'b1;
      dacRst_o <= 1'b1;
    end else begin
      dacRst_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/routeCfgIf.sv */
`default_nettype none

// route and mode settings from the register block
interface routeCfgIf;
  import routerPkg::*;

  dacInSelT dacInSel [NumDacs];
  decInSelT decInSel;
  qOutSelT  qOutSel;
  logic     trellisMode;  // pcm trellis or soqpsk
  logic     auQpskMode;   // aqpsk or auqpsk

  modport regs (output dacInSel, decInSel, qOutSel, trellisMode, auQpskMode);
  modport router (input dacInSel, decInSel, trellisMode);
  modport formatter (input qOutSel, auQpskMode);
endinterface

// selected streams from the router to the formatter
interface routeOutIf;
  import routerPkg::*;

  sampleT    dacSample [NumDacs];
  bitStreamT decBits;
  logic      scQBit;   // subcarrier q, aligned with decBits
  logic      rawQBit;  // demod q, aligned with decBits

  modport source (output dacSample, decBits, scQBit, rawQBit);
  modport sink (input dacSample, decBits, scQBit, rawQBit);
endinterface

`default_nettype wire

/* hw/routerPkg.sv */
`default_nettype none

package routerPkg;

  // ******************************
  // widths and constants
  // ******************************
  localparam int SampleWidth     = 18;  // internal sample path
  localparam int DemodWidth      = 14;  // demod inputs and DAC codes
  localparam int PadZeros        = SampleWidth - DemodWidth;
  localparam int NumDacs         = 3;
  localparam int SoftResetCycles = 6;
  localparam int RstCntWidth     = $clog2(SoftResetCycles + 1);
  localparam int AddrWidth       = 4;

  localparam logic [15:0] VersionNumber = 16'd435;
  localparam logic [15:0] ImageType     = 16'h0002;
  localparam logic [1:0]  RespOkay      = 2'b00;

  // register byte addresses
  localparam logic [AddrWidth-1:0] RegVersion = 4'h0;
  localparam logic [AddrWidth-1:0] RegRoute   = 4'h4;
  localparam logic [AddrWidth-1:0] RegReset   = 4'h8;

  // demod modes seen on the pads
  localparam logic [4:0] ModeAqpsk      = 5'd5;
  localparam logic [4:0] ModeAuqpsk     = 5'd6;
  localparam logic [4:0] ModePcmTrellis = 5'd8;
  localparam logic [4:0] ModeSoqpsk     = 5'd9;

  // dacSelect codes owned by the trellis
  localparam logic [3:0] DacTrellisI     = 4'hC;
  localparam logic [3:0] DacTrellisQ     = 4'hD;
  localparam logic [3:0] DacTrellisPhErr = 4'hE;
  localparam logic [3:0] DacTrellisIndex = 4'hF;

  // ******************************
  // types
  // ******************************
  typedef enum logic [1:0] {SelDemod = 2'd0, SelSubcarrier = 2'd1} dacInSelT;
  typedef enum logic [1:0] {DecDemod = 2'd0, DecSubcarrier = 2'd1} decInSelT;
  typedef enum logic [1:0] {QOutDecoder = 2'd0, QOutSubcarrier = 2'd1} qOutSelT;

  typedef struct packed {
    logic [SampleWidth-1:0] data;
    logic                   sync;  // sample valid strobe
  } sampleT;

  typedef struct packed {
    logic iBit;
    logic qBit;
    logic symEn;
    logic sym2xEn;
  } bitStreamT;

endpackage

`default_nettype wire
